/* hdl/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_BNE = 6'h05;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same 32 bits, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_t;

    // word1 at pc, word2 at pc + 4
    typedef struct packed {
        logic [31:0] pc;
        inst_word_t  word1;
        inst_word_t  word2;
    } fetch_pair_t;

    typedef struct packed {
        inst_word_t  word;
        logic [31:0] pc;
    } queue_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_word_t  word;
        logic        is_branch;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
    } issue_slot_t;

    typedef struct packed {
        issue_slot_t slot1;
        issue_slot_t slot2;
        logic        delay_slot;
    } issue_pair_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] target;
    } resolve_t;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                        clk,
    input  wire                        rst,

    output logic                       imem_req,
    output logic [31:0]                imem_addr,
    input  wire                        imem_ack,
    input  wire frontend_pkg::fetch_pair_t imem_data,

    output logic                       wr_en,
    output frontend_pkg::fetch_pair_t  wr_pair,
    input  wire                        full,

    input  wire                        flush,
    input  wire [31:0]                 flush_target
);

    logic [31:0] pc;
    logic [31:0] req_addr;
    logic        stale;
    logic        accept;
    logic        start_req;

    assign imem_addr = req_addr;

    // Response is kept only if no redirect happened while it was open
    assign accept = imem_req && imem_ack && !stale && !flush;

    // Pending write must land first so full reflects it
    assign start_req = !imem_req && !imem_ack && !wr_en && !full && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            imem_req <= 1'b0;
            wr_en    <= 1'b0;
            stale    <= 1'b0;
            pc       <= RESET_PC;
            req_addr <= RESET_PC;
        end else begin
            wr_en <= 1'b0;
            if (imem_req) begin
                if (imem_ack) begin
                    imem_req <= 1'b0;
                    wr_en    <= accept;
                    stale    <= 1'b0;
                    if (accept) begin
                        pc <= pc + 32'd8;
                    end
                end else if (flush) begin
                    stale <= 1'b1;
                end
            end else if (start_req) begin
                imem_req <= 1'b1;
                req_addr <= pc;
            end
            if (flush) begin
                pc <= flush_target;
            end
        end
    end

    // Payload only, written with the captured response
    always_ff @(posedge clk) begin
        if (imem_req && imem_ack) begin
            wr_pair.pc    <= req_addr;
            wr_pair.word1 <= imem_data.word1;
            wr_pair.word2 <= imem_data.word2;
        end
    end

endmodule

`default_nettype wire

/* hdl/inst_queue.sv */
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                              clk,
    input  wire                              rst,

    input  wire                              wr_en,
    input  wire frontend_pkg::fetch_pair_t   wr_pair,
    output logic                             full,

    input  wire [1:0]                        pop,
    input  wire                              flush,

    output frontend_pkg::queue_entry_t       head1,
    output frontend_pkg::queue_entry_t       head2,
    output logic [$clog2(QUEUE_DEPTH):0]     count,
    output logic                             empty,
    output logic                             delay_flag
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    frontend_pkg::queue_entry_t mem [QUEUE_DEPTH];
    frontend_pkg::queue_entry_t ret_entry;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] occ;
    logic [CNT_W-1:0] occ_add;
    logic [CNT_W-1:0] occ_sub;

    assign wr_ptr_nxt = wr_ptr + PTR_W'(1);
    assign rd_ptr_nxt = rd_ptr + PTR_W'(1);

    // Retained delay slot counts as one entry in front of the ring
    assign count = delay_flag ? CNT_W'(1) : occ;
    assign empty = (count == '0);

    // Two free slots are reserved so a whole pair always fits
    assign full = (occ >= CNT_W'(QUEUE_DEPTH - 2));

    assign occ_add = wr_en ? CNT_W'(2) : '0;
    assign occ_sub = delay_flag ? '0 : CNT_W'(pop);

    always_comb begin
        if (delay_flag) begin
            head1 = ret_entry;
            head2 = '0;
        end else begin
            head1 = mem[rd_ptr];
            head2 = (occ >= CNT_W'(2)) ? mem[rd_ptr_nxt] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ        <= '0;
            delay_flag <= 1'b0;
        end else if (flush) begin
            // Branch already popped, so the head is its delay slot
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ        <= '0;
            delay_flag <= !empty;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(2);
            end
            if (delay_flag) begin
                if (pop != 2'd0) begin
                    delay_flag <= 1'b0;
                end
            end else begin
                rd_ptr <= rd_ptr + PTR_W'(pop);
            end
            occ <= occ + occ_add - occ_sub;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            ret_entry <= head1;
        end
    end

    // Writes arriving with a flush belong to the old path
    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            mem[wr_ptr].word     <= wr_pair.word1;
            mem[wr_ptr].pc       <= wr_pair.pc;
            mem[wr_ptr_nxt].word <= wr_pair.word2;
            mem[wr_ptr_nxt].pc   <= wr_pair.pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
`default_nettype none

module issue_stage #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                              clk,
    input  wire                              rst,

    input  wire frontend_pkg::queue_entry_t  head1,
    input  wire frontend_pkg::queue_entry_t  head2,
    input  wire [$clog2(QUEUE_DEPTH):0]      count,
    input  wire                              empty,
    input  wire                              delay_flag,
    output logic [1:0]                       pop,

    output logic                             iss_req,
    output frontend_pkg::issue_pair_t        iss_pair,
    input  wire                              iss_ack,

    input  wire frontend_pkg::resolve_t      resolve,
    output logic                             flush,
    output logic [31:0]                      flush_target
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_t;

    state_t                    state;
    frontend_pkg::issue_slot_t s1;
    frontend_pkg::issue_slot_t s2;
    frontend_pkg::issue_pair_t next_pair;
    logic                      can_issue;
    logic                      two_ok;

    function automatic frontend_pkg::issue_slot_t decode_slot(
        input frontend_pkg::queue_entry_t e,
        input logic                       v
    );
        frontend_pkg::issue_slot_t s;
        s           = '0;
        s.valid     = v;
        s.pc        = e.pc;
        s.word      = e.word;
        s.is_branch = v && (e.word.i.opcode == frontend_pkg::OP_BEQ ||
                            e.word.i.opcode == frontend_pkg::OP_BNE);
        // Opcode zero is the R format
        if (e.word.r.opcode == 6'd0) begin
            s.rs = e.word.r.rs;
            s.rt = e.word.r.rt;
            s.rd = e.word.r.rd;
        end else begin
            s.rs  = e.word.i.rs;
            s.rt  = e.word.i.rt;
            s.imm = e.word.i.imm;
        end
        return s;
    endfunction

    assign two_ok = (count >= 2);

    always_comb begin
        s1                   = decode_slot(head1, !empty);
        s2                   = decode_slot(head2, two_ok && !delay_flag);
        next_pair.slot1      = s1;
        next_pair.slot2      = s2;
        next_pair.delay_slot = 1'b0;
        can_issue            = !empty;
        if (delay_flag) begin
            next_pair.slot2      = '0;
            next_pair.delay_slot = 1'b1;
        end else if (s1.is_branch) begin
            // Delay slot must already be queued behind the branch
            next_pair.slot2 = '0;
            can_issue       = two_ok;
        end else if (s2.is_branch) begin
            next_pair.slot2 = '0;
        end
    end

    assign iss_req      = (state == S_REQ);
    assign pop          = (iss_req && iss_ack) ?
                          (2'(iss_pair.slot1.valid) + 2'(iss_pair.slot2.valid)) : 2'd0;
    assign flush        = (state == S_WAIT) && resolve.valid && resolve.taken;
    assign flush_target = resolve.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (can_issue && !iss_ack) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (iss_ack) begin
                        if (iss_pair.slot1.is_branch && !iss_pair.delay_slot) begin
                            state <= S_WAIT;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    if (resolve.valid) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Pair is frozen once req is up
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            iss_pair <= next_pair;
        end
    end

endmodule

`default_nettype wire

/* hdl/frontend_top.sv */
`default_nettype none

module frontend_top #(
    parameter int          QUEUE_DEPTH = 16,
    parameter logic [31:0] RESET_PC    = 32'h0000_0000
) (
    input  wire                              clk,
    input  wire                              rst,

    output logic                             imem_req,
    output logic [31:0]                      imem_addr,
    input  wire                              imem_ack,
    input  wire frontend_pkg::fetch_pair_t   imem_data,

    output logic                             iss_req,
    output frontend_pkg::issue_pair_t        iss_pair,
    input  wire                              iss_ack,

    input  wire frontend_pkg::resolve_t      resolve
);

    frontend_pkg::fetch_pair_t   wr_pair;
    frontend_pkg::queue_entry_t  head1;
    frontend_pkg::queue_entry_t  head2;
    logic [$clog2(QUEUE_DEPTH):0] count;
    logic                        wr_en;
    logic                        full;
    logic                        empty;
    logic                        delay_flag;
    logic [1:0]                  pop;
    logic                        flush;
    logic [31:0]                 flush_target;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_ack     (imem_ack),
        .imem_data    (imem_data),
        .wr_en        (wr_en),
        .wr_pair      (wr_pair),
        .full         (full),
        .flush        (flush),
        .flush_target (flush_target)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_pair    (wr_pair),
        .full       (full),
        .pop        (pop),
        .flush      (flush),
        .head1      (head1),
        .head2      (head2),
        .count      (count),
        .empty      (empty),
        .delay_flag (delay_flag)
    );

    issue_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue (
        .clk          (clk),
        .rst          (rst),
        .head1        (head1),
        .head2        (head2),
        .count        (count),
        .empty        (empty),
        .delay_flag   (delay_flag),
        .pop          (pop),
        .iss_req      (iss_req),
        .iss_pair     (iss_pair),
        .iss_ack      (iss_ack),
        .resolve      (resolve),
        .flush        (flush),
        .flush_target (flush_target)
    );

endmodule

`default_nettype wire

/* verif/frontend_checker.sv */
`default_nettype none

module frontend_checker (
    input wire                              clk,
    input wire                              rst,
    input wire                              imem_req,
    input wire [31:0]                       imem_addr,
    input wire                              imem_ack,
    input wire                              iss_req,
    input wire frontend_pkg::issue_pair_t   iss_pair,
    input wire                              iss_ack
);

    // Four-phase rules on the memory channel
    imem_req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    imem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        imem_req && $past(imem_req) |-> $stable(imem_addr))
        else $error("imem_addr changed while imem_req high");

    imem_no_early_req: assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req) |-> !imem_ack)
        else $error("imem_req rose while imem_ack high");

    // Same rules on the issue channel
    iss_req_held: assert property (@(posedge clk) disable iff (rst)
        iss_req && !iss_ack |=> iss_req)
        else $error("iss_req dropped before iss_ack");

    iss_pair_stable: assert property (@(posedge clk) disable iff (rst)
        iss_req && $past(iss_req) |-> $stable(iss_pair))
        else $error("iss_pair changed while iss_req high");

    iss_no_early_req: assert property (@(posedge clk) disable iff (rst)
        $rose(iss_req) |-> !iss_ack)
        else $error("iss_req rose while iss_ack high");

    delay_slot_alone: assert property (@(posedge clk) disable iff (rst)
        iss_req && iss_pair.delay_slot |-> !iss_pair.slot2.valid)
        else $error("delay slot issued with a valid slot2");

endmodule

bind frontend_top frontend_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .iss_req   (iss_req),
    .iss_pair  (iss_pair),
    .iss_ack   (iss_ack)
);

`default_nettype wire

/* verif/frontend_tb.sv */
`default_nettype none

module frontend_tb;

    localparam int          QUEUE_DEPTH = 16;
    localparam logic [31:0] RESET_PC    = 32'h0000_0000;

    logic                      clk;
    logic                      rst;
    logic                      imem_req;
    logic [31:0]               imem_addr;
    logic                      imem_ack;
    frontend_pkg::fetch_pair_t imem_data;
    logic                      iss_req;
    frontend_pkg::issue_pair_t iss_pair;
    logic                      iss_ack;
    frontend_pkg::resolve_t    resolve;

    logic [31:0] tdata [0:255];
    int n_prog;
    int n_res;
    int n_exp;
    int res_base;
    int exp_base;
    int exp_idx;
    int br_idx;
    int seed;
    int cycles;
    int cycle_limit;
    int checks;
    int errors;
    int err_reset;
    int err_addr;
    int err_stream;
    int err_rules;
    int err_decode;
    bit first_req;
    bit saw_full;

    frontend_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .iss_req   (iss_req),
        .iss_pair  (iss_pair),
        .iss_ack   (iss_ack),
        .resolve   (resolve)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (idx < n_prog) begin
            return tdata[3 + idx];
        end
        return 32'd0;
    endfunction

    // Branch opcodes are BEQ and BNE
    function automatic bit is_branch_word(input logic [31:0] w);
        return (w[31:26] == 6'h04) || (w[31:26] == 6'h05);
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expv, output bit bad);
        bad = 1'b0;
        checks++;
        if (got !== expv) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expv);
            errors++;
            bad = 1'b1;
        end
    endtask

    task automatic rule_error(input string what);
        checks++;
        errors++;
        err_rules++;
        $display("Error at t=%0t: %s", $time, what);
    endtask

    task automatic check_slot(input logic [31:0] pc, input logic [31:0] word,
                              input logic delay);
        int base;
        bit bad;
        if (exp_idx >= n_exp) begin
            return;
        end
        base = exp_base + 3 * exp_idx;
        compare("slot.pc", pc, tdata[base], bad);
        err_stream += bad;
        compare("slot.word", word, tdata[base + 1], bad);
        err_stream += bad;
        compare("delay_slot", 32'(delay), tdata[base + 2], bad);
        err_stream += bad;
        exp_idx++;
    endtask

    // Field positions follow the MIPS R and I formats
    task automatic check_decode(input frontend_pkg::issue_slot_t s);
        logic [31:0] w;
        bit          bad;
        w = s.word;
        compare("slot.is_branch", 32'(s.is_branch), 32'(is_branch_word(w)), bad);
        err_decode += bad;
        compare("slot.rs", 32'(s.rs), 32'(w[25:21]), bad);
        err_decode += bad;
        compare("slot.rt", 32'(s.rt), 32'(w[20:16]), bad);
        err_decode += bad;
        if (w[31:26] == 6'd0) begin
            compare("slot.rd", 32'(s.rd), 32'(w[15:11]), bad);
        end else begin
            compare("slot.imm", 32'(s.imm), 32'(w[15:0]), bad);
        end
        err_decode += bad;
    endtask

    task automatic check_pair(input frontend_pkg::issue_pair_t p);
        bit bad;
        if (!p.slot1.valid) begin
            rule_error("transfer with slot1 empty");
        end
        if (p.slot2.valid && is_branch_word(p.slot2.word)) begin
            rule_error("branch issued in slot2");
        end
        if (is_branch_word(p.slot1.word) && p.slot2.valid) begin
            rule_error("branch issued together with a second entry");
        end
        if (p.delay_slot && p.slot2.valid) begin
            rule_error("delay slot issued with a valid slot2");
        end
        if (p.slot2.valid) begin
            compare("slot2.pc", p.slot2.pc, p.slot1.pc + 32'd4, bad);
            err_rules += bad;
        end
        if (p.slot1.valid) begin
            check_slot(p.slot1.pc, p.slot1.word, p.delay_slot);
            check_decode(p.slot1);
        end
        if (p.slot2.valid) begin
            check_slot(p.slot2.pc, p.slot2.word, 1'b0);
            check_decode(p.slot2);
        end
    endtask

    // Instruction memory responder
    initial begin
        int delay;
        bit bad;
        forever begin
            @(posedge clk);
            if (!rst && imem_req && !imem_ack) begin
                if (first_req) begin
                    compare("imem_addr", imem_addr, RESET_PC, bad);
                    err_addr += bad;
                    first_req = 1'b0;
                end
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                imem_data <= {imem_addr, prog_word(imem_addr), prog_word(imem_addr + 32'd4)};
                imem_ack  <= 1'b1;
                do @(posedge clk); while (imem_req);
                imem_ack <= 1'b0;
            end
        end
    end

    // Back-end responder, resolves each branch after its transfer
    initial begin
        int delay;
        frontend_pkg::issue_pair_t p;
        forever begin
            @(posedge clk);
            if (!rst && iss_req && !iss_ack) begin
                delay = $unsigned($random(seed)) % 4;
                // Long hold on the first transfer lets fetch run the queue full
                if (exp_idx == 0) begin
                    delay = delay + 56;
                end
                repeat (delay) @(posedge clk);
                p = iss_pair;
                check_pair(p);
                iss_ack <= 1'b1;
                do @(posedge clk); while (iss_req);
                iss_ack <= 1'b0;
                if (is_branch_word(p.slot1.word) && !p.delay_slot) begin
                    delay = $unsigned($random(seed)) % 4;
                    repeat (delay) @(posedge clk);
                    if (br_idx < n_res) begin
                        resolve <= {1'b1, tdata[res_base + 2 * br_idx][0],
                                    tdata[res_base + 2 * br_idx + 1]};
                    end else begin
                        resolve <= {1'b1, 1'b0, 32'd0};
                    end
                    br_idx++;
                    @(posedge clk);
                    resolve <= '0;
                end
            end
        end
    end

    // Queue probe for back-pressure
    always @(posedge clk) begin
        if (!rst && u_dut.full) begin
            saw_full <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("Timeout: issue stream incomplete after %0d cycles", cycle_limit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin
        bit bad;
        seed      = 62624;
        clk       = 1'b0;
        rst       = 1'b1;
        imem_ack  = 1'b0;
        imem_data = '0;
        iss_ack   = 1'b0;
        resolve   = '0;
        first_req = 1'b1;
        $readmemh("verif/frontend_testdata.txt", tdata);
        n_prog      = int'(tdata[0]);
        n_res       = int'(tdata[1]);
        n_exp       = int'(tdata[2]);
        res_base    = 3 + n_prog;
        exp_base    = res_base + 2 * n_res;
        cycle_limit = 40 * n_exp;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        compare("imem_req", 32'(imem_req), 32'd0, bad);
        err_reset += bad;
        compare("iss_req", 32'(iss_req), 32'd0, bad);
        err_reset += bad;
        $display("Test reset_state: %s", (err_reset == 0) ? "ok" : "errors");

        while (exp_idx < n_exp) begin
            @(posedge clk);
        end
        $display("Test first_fetch_addr: %s", (err_addr == 0) ? "ok" : "errors");
        $display("Test issue_stream: %s", (err_stream == 0) ? "ok" : "errors");
        $display("Test slot_decode: %s", (err_decode == 0) ? "ok" : "errors");
        $display("Test pair_rules: %s", (err_rules == 0) ? "ok" : "errors");
        if (!saw_full) begin
            rule_error("queue never reached full");
        end
        $display("Test queue_full: %s", saw_full ? "ok" : "errors");
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frontend_top.f */
hdl/frontend_pkg.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/issue_stage.sv
hdl/frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module frontend_tb \
    -f frontend_top.f \
    -o frontend_sim

output=$(./obj_dir/frontend_sim)
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

/* verif/frontend_testdata.txt */
// Header: program word count, resolve count, expected entry count
// Then program words from RESET_PC, resolves as taken/target, expected as pc/word/delay
10 3 e
00221821 24840001 00642825 10220004
00c73021 24a50002 24a50003 24a50004
00853021 14430003 24060007 00e73825
24080009 1000fff2 01094021 24090001
1 00000020
0 00000000
1 00000000
00000000 00221821 0
00000004 24840001 0
00000008 00642825 0
0000000c 10220004 0
00000010 00c73021 1
00000020 00853021 0
00000024 14430003 0
00000028 24060007 0
0000002c 00e73825 0
00000030 24080009 0
00000034 1000fff2 0
00000038 01094021 1
00000000 00221821 0
00000004 24840001 0
